// ==== Makefile ====
SIM := obj_dir/Vtb_riscv_m_unit
SRCS := $(wildcard hw/*.sv bench/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): list.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_riscv_m_unit -f list.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASS" sim.log || (echo "simulation ended early"; exit 1)

clean:
	rm -rf obj_dir sim.log

// ==== bench/riscv_m_checker.sv ====
`timescale 1ns/1ps

module riscv_m_checker (
	input  logic                                i_riscv_clk,
	input  logic                                i_reset,
	input  logic                                i_valid,
	input  logic [riscv_m_pkg::REG_W-1:0]       i_rd,
	input  logic                                o_valid,
	input  logic [riscv_m_pkg::REG_W-1:0]       o_rd
);

	// writeback clears on the first edge that sees reset
	a_reset_clears: assert property (@(posedge i_riscv_clk)
		i_reset |=> !o_valid)
		else $error("o_valid high one cycle into reset");

	// two register stages, so exactly two cycles
	a_latency: assert property (@(posedge i_riscv_clk) disable iff (i_reset)
		$past(i_valid, 2) |-> o_valid)
		else $error("request did not produce o_valid two cycles later");

	// tag rides with the request
	a_tag: assert property (@(posedge i_riscv_clk) disable iff (i_reset)
		o_valid |-> (o_rd == $past(i_rd, 2)))
		else $error("o_rd does not match i_rd from two cycles earlier");

	// no result without a request behind it
	a_no_stray: assert property (@(posedge i_riscv_clk) disable iff (i_reset)
		o_valid |-> $past(i_valid, 2))
		else $error("o_valid without a request two cycles earlier");

endmodule

// ==== bench/tb_riscv_m_unit.sv ====
`timescale 1ns/1ps

module tb_riscv_m_unit;

	localparam int CLK_PERIOD = 20;	// ns
	localparam int N_MUL      = 64;
	localparam int N_DIV      = 64;
	localparam int N_REM      = 64;
	localparam int N_CORNER   = 24;	// 6 operand pairs x 4 divider ops
	localparam int N_B2B      = 32;	// one per rd tag
	localparam int N_RST      = 12;	// 8 before the reset and 4 after
	localparam int TOTAL_REQ  = N_MUL + N_DIV + N_REM + N_CORNER + N_B2B + N_RST;
	// one cycle per request plus reset, drains and slack
	localparam int WATCHDOG_CYCLES = TOTAL_REQ + 200;

	localparam logic [63:0] MIN_NEG  = 64'h8000_0000_0000_0000;
	localparam logic [63:0] ALL_ONES = 64'hffff_ffff_ffff_ffff;

	logic        i_riscv_clk;
	logic        i_reset;
	logic        i_valid;
	logic [2:0]  i_funct3;
	logic [63:0] i_rs1data;
	logic [63:0] i_rs2data;
	logic [4:0]  i_rd;
	logic        o_valid;
	logic [63:0] o_result;
	logic [4:0]  o_rd;

	logic [63:0] exp_q[$];	// expected result per request in flight
	logic [4:0]  rd_q[$];
	int unsigned seen_q[$];	// negedge at which the request sat on the pins

	int unsigned cyc = 0;	// negedge count
	logic        rst_seen = 1'b1;	// reset was high at the last negedge
	int          errors = 0;
	int          n_sent = 0;
	int          n_checked = 0;
	int          n_dropped = 0;
	logic [63:0] rng_state = 64'd66926;

	riscv_m_unit DUT (
		.i_riscv_clk (i_riscv_clk),
		.i_reset     (i_reset),
		.i_valid     (i_valid),
		.i_funct3    (i_funct3),
		.i_rs1data   (i_rs1data),
		.i_rs2data   (i_rs2data),
		.i_rd        (i_rd),
		.o_valid     (o_valid),
		.o_result    (o_result),
		.o_rd        (o_rd)
	);

	// timing assertions on the top level ports
	bind riscv_m_unit riscv_m_checker u_checker (
		.i_riscv_clk (i_riscv_clk),
		.i_reset     (i_reset),
		.i_valid     (i_valid),
		.i_rd        (i_rd),
		.o_valid     (o_valid),
		.o_rd        (o_rd)
	);

	initial
	begin
		i_riscv_clk = 1'b0;
		forever #(CLK_PERIOD / 2) i_riscv_clk = ~i_riscv_clk;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles and results stopped arriving",
			WATCHDOG_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

	// xorshift64 with shifts 13 7 17
	function automatic logic [63:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 7);
		rng_state = rng_state ^ (rng_state << 17);
		return rng_state;
	endfunction

	// random word with the corner values mixed in
	function automatic logic [63:0] pick_operand();
		logic [63:0] sel;
		logic [63:0] r;
		sel = next_rand();
		r   = next_rand();
		case (sel[3:0])
			4'd0:       return 64'd0;
			4'd1:       return 64'd1;
			4'd2:       return ALL_ONES;	// -1 when signed
			4'd3:       return MIN_NEG;
			4'd4:       return r | MIN_NEG;	// top bit set
			4'd5, 4'd6: return r >> sel[9:4];	// shorter magnitudes for varied quotients
			default:    return r;
		endcase
	endfunction

	// expected result from 128 bit arithmetic
	function automatic logic [63:0] ref_result(input logic [2:0] f3, input logic [63:0] a,
		input logic [63:0] b);
		logic signed [127:0] sa;
		logic signed [127:0] sb;
		logic signed [127:0] ua;
		logic signed [127:0] ub;
		logic signed [127:0] full;
		sa = {{64{a[63]}}, a};
		sb = {{64{b[63]}}, b};
		ua = {64'd0, a};	// nonnegative so signed math is exact
		ub = {64'd0, b};
		case (riscv_m_pkg::m_op_e'(f3))
			riscv_m_pkg::MUL:    full = sa * sb;
			riscv_m_pkg::MULH:   full = (sa * sb) >>> 64;
			riscv_m_pkg::MULHSU: full = (sa * ub) >>> 64;
			riscv_m_pkg::MULHU:  full = (ua * ub) >>> 64;
			// divide by zero gives -1 and remainder by zero gives the dividend
			riscv_m_pkg::DIV:    full = (b == 64'd0) ? -128'sd1 : sa / sb;
			riscv_m_pkg::DIVU:   full = (b == 64'd0) ? -128'sd1 : ua / ub;
			riscv_m_pkg::REM:    full = (b == 64'd0) ? sa : sa % sb;
			default:             full = (b == 64'd0) ? ua : ua % ub;
		endcase
		// min / -1 is 2^63 here and wraps back to the dividend
		return full[63:0];
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// one request on the next rising edge
	task automatic issue(input logic [2:0] f3, input logic [63:0] a, input logic [63:0] b,
		input logic [4:0] rd);
		@(posedge i_riscv_clk);
		i_valid   <= 1'b1;
		i_funct3  <= f3;
		i_rs1data <= a;
		i_rs2data <= b;
		i_rd      <= rd;
		exp_q.push_back(ref_result(f3, a, b));
		rd_q.push_back(rd);
		seen_q.push_back(cyc + 1);
		n_sent++;
	endtask

	// back to back requests with op set to base plus random bits under mask
	task automatic run_random(input int n, input logic [2:0] base, input logic [2:0] mask);
		logic [63:0] r;
		for (int i = 0; i < n; i++)
		begin
			r = next_rand();
			issue(base | (r[2:0] & mask), pick_operand(), pick_operand(), 5'(i));
		end
	endtask

	task automatic run_corners();
		logic [63:0] a [6];
		logic [63:0] b [6];
		a = '{MIN_NEG, MIN_NEG, ALL_ONES, 64'd0, 64'd12345, 64'h7fff_ffff_ffff_ffff};
		b = '{64'd0, ALL_ONES, 64'd0, 64'd0, ALL_ONES, 64'd1};
		for (int p = 0; p < 6; p++)
		begin
			for (int op = 4; op < 8; op++)
			begin
				issue(3'(op), a[p], b[p], 5'(p * 4 + op));
			end
		end
	endtask

	// reset lands while requests are still in the pipe
	task automatic run_reset_test();
		run_random(8, 3'b000, 3'b111);
		@(posedge i_riscv_clk);
		i_valid <= 1'b0;
		i_reset <= 1'b1;
		repeat (3) @(posedge i_riscv_clk);
		i_reset <= 1'b0;
		repeat (4) @(posedge i_riscv_clk);	// any stale result shows up here
		run_random(4, 3'b000, 3'b111);
	endtask

	task automatic drain();
		@(posedge i_riscv_clk);
		i_valid <= 1'b0;
		while (exp_q.size() != 0)
			@(posedge i_riscv_clk);
		repeat (2) @(posedge i_riscv_clk);
	endtask

	task automatic end_test(input int num, input string name, input int sent0, input int err0);
		drain();
		$display("test %0d %s: %0d requests, %0d errors", num, name, n_sent - sent0,
			errors - err0);
	endtask

	// outputs are settled at the falling edge
	always @(negedge i_riscv_clk)
	begin
		cyc = cyc + 1;
		if (rst_seen)
		begin
			if (o_valid !== 1'b0)
			begin
				$display("o_valid was not low while reset was held, at %0t", $time);
				errors++;
			end
			n_dropped += exp_q.size();	// in flight requests are lost
			exp_q.delete();
			rd_q.delete();
			seen_q.delete();
		end
		else if (o_valid === 1'b1)
		begin
			if (exp_q.size() == 0)
			begin
				$display("a result came out with no request outstanding, at %0t", $time);
				errors++;
			end
			else
			begin
				check_value("o_result", o_result, exp_q.pop_front());
				check_value("o_rd", 64'(o_rd), 64'(rd_q.pop_front()));
				check_value("latency", 64'(cyc - seen_q.pop_front()), 64'd2);
				n_checked++;
			end
		end
		else if (o_valid !== 1'b0)
		begin
			$display("o_valid is unknown at %0t", $time);
			errors++;
		end
		rst_seen = i_reset;
	end

	initial
	begin
		int sent0;
		int err0;
		i_reset   = 1'b1;
		i_valid   = 1'b0;
		i_funct3  = 3'd0;
		i_rs1data = 64'd0;
		i_rs2data = 64'd0;
		i_rd      = 5'd0;
		repeat (5) @(posedge i_riscv_clk);
		i_reset <= 1'b0;

		sent0 = n_sent;
		err0  = errors;
		run_random(N_MUL, 3'b000, 3'b011);	// mul, mulh, mulhsu, mulhu
		end_test(1, "multiply", sent0, err0);
		sent0 = n_sent;
		err0  = errors;
		run_random(N_DIV, 3'b100, 3'b001);	// div, divu
		end_test(2, "divide", sent0, err0);
		sent0 = n_sent;
		err0  = errors;
		run_random(N_REM, 3'b110, 3'b001);	// rem, remu
		end_test(3, "remainder", sent0, err0);
		sent0 = n_sent;
		err0  = errors;
		run_corners();
		end_test(4, "divider corners", sent0, err0);
		sent0 = n_sent;
		err0  = errors;
		run_random(N_B2B, 3'b000, 3'b111);	// every op, tags 0..31
		end_test(5, "back to back", sent0, err0);
		sent0 = n_sent;
		err0  = errors;
		run_reset_test();
		end_test(6, "mid-stream reset", sent0, err0);

		$display("requests %0d, checked %0d, dropped by reset %0d, errors %0d",
			n_sent, n_checked, n_dropped, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== hw/riscv_divider.sv ====
`timescale 1ns/1ps

module riscv_divider (
	riscv_m_req_if.exec                        req,
	output logic [riscv_m_pkg::XLEN-1:0]       o_riscv_div_result
);

	logic                               div_unsigned;	// divu or remu
	logic                               rs1_neg;	// dividend sign, signed ops only
	logic                               rs2_neg;	// divisor sign, signed ops only
	logic [riscv_m_pkg::XLEN-1:0]       dvd_mag;	// dividend magnitude
	logic [riscv_m_pkg::XLEN-1:0]       dvs_mag;	// divisor magnitude
	logic [riscv_m_pkg::XLEN-1:0]       quot;	// shifts the dividend out, quotient in
	logic [riscv_m_pkg::XLEN:0]         rem;	// partial remainder, extra bit for the sign
	logic                               div_by_zero;
	logic                               overflow;	// most negative over minus one
	logic                               dvs_big;	// unsigned divisor with the top bit set
	logic                               rs1_ge_rs2;	// unsigned compare for the dvs_big case

	assign div_unsigned = req.op[riscv_m_pkg::UNSIGNED_BIT];
	assign rs1_neg      = !div_unsigned && req.rs1data[riscv_m_pkg::XLEN-1];
	assign rs2_neg      = !div_unsigned && req.rs2data[riscv_m_pkg::XLEN-1];

	// two's complement only when the op is signed and the value negative
	// the most negative value maps to 2^63, which still fits unsigned
	assign dvd_mag = rs1_neg ? (~req.rs1data + 1'b1) : req.rs1data;
	assign dvs_mag = rs2_neg ? (~req.rs2data + 1'b1) : req.rs2data;

	assign div_by_zero = (req.rs2data == '0);
	assign overflow    = (req.rs1data == {1'b1, {(riscv_m_pkg::XLEN-1){1'b0}}}) &&
	                     (req.rs2data == '1);
	assign dvs_big     = req.rs2data[riscv_m_pkg::XLEN-1];
	assign rs1_ge_rs2  = (req.rs1data >= req.rs2data);

	// 64 step restoring loop, one quotient bit per step
	always_comb
	begin
		rem  = '0;
		quot = dvd_mag;
		for (int i = 0; i < riscv_m_pkg::XLEN; i++)
		begin
			// bring the next dividend bit into the remainder
			rem  = {rem[riscv_m_pkg::XLEN-1:0], quot[riscv_m_pkg::XLEN-1]};
			quot = {quot[riscv_m_pkg::XLEN-2:0], 1'b0};
			rem  = rem - {1'b0, dvs_mag};	// trial subtract
			if (rem[riscv_m_pkg::XLEN])
			begin
				rem = rem + {1'b0, dvs_mag};	// went negative, put it back
				quot[0] = 1'b0;
			end
			else
			begin
				quot[0] = 1'b1;	// divisor fit
			end
		end
	end

	// result select with sign fixup and the RISC-V corner cases
	always_comb
	begin
		case (req.op)
			riscv_m_pkg::DIV:
			begin
				if (div_by_zero)
				begin
					o_riscv_div_result = '1;	// -1
				end
				else if (overflow)
				begin
					o_riscv_div_result = req.rs1data;	// quotient wraps to the dividend
				end
				else if (rs1_neg != rs2_neg)
				begin
					o_riscv_div_result = ~quot + 1'b1;	// signs differ
				end
				else
				begin
					o_riscv_div_result = quot;
				end
			end
			riscv_m_pkg::DIVU:
			begin
				if (div_by_zero)
				begin
					o_riscv_div_result = '1;	// 2^64-1
				end
				else if (dvs_big)
				begin
					// quotient can only be 0 or 1 here
					o_riscv_div_result = {{(riscv_m_pkg::XLEN-1){1'b0}}, rs1_ge_rs2};
				end
				else
				begin
					o_riscv_div_result = quot;
				end
			end
			riscv_m_pkg::REM:
			begin
				if (div_by_zero)
				begin
					o_riscv_div_result = req.rs1data;
				end
				else if (overflow)
				begin
					o_riscv_div_result = '0;
				end
				else if (rs1_neg)
				begin
					// remainder takes the dividend's sign
					o_riscv_div_result = ~rem[riscv_m_pkg::XLEN-1:0] + 1'b1;
				end
				else
				begin
					o_riscv_div_result = rem[riscv_m_pkg::XLEN-1:0];
				end
			end
			riscv_m_pkg::REMU:
			begin
				if (div_by_zero)
				begin
					o_riscv_div_result = req.rs1data;
				end
				else if (dvs_big)
				begin
					// at most one subtract fits
					o_riscv_div_result = rs1_ge_rs2 ? (req.rs1data - req.rs2data) :
					                                  req.rs1data;
				end
				else
				begin
					o_riscv_div_result = rem[riscv_m_pkg::XLEN-1:0];
				end
			end
			default:
			begin
				o_riscv_div_result = '0;	// mul op, not selected
			end
		endcase
	end

endmodule

// ==== hw/riscv_m_issue.sv ====
`timescale 1ns/1ps

module riscv_m_issue (
	input  logic                                i_riscv_clk,
	input  logic                                i_reset,
	input  logic                                i_valid,
	input  logic [riscv_m_pkg::OP_W-1:0]        i_funct3,
	input  logic [riscv_m_pkg::XLEN-1:0]        i_rs1data,
	input  logic [riscv_m_pkg::XLEN-1:0]        i_rs2data,
	input  logic [riscv_m_pkg::REG_W-1:0]       i_rd,
	riscv_m_req_if.issue                        req
);

	riscv_m_pkg::m_op_e op_dec;	// funct3 seen as an opcode

	// funct3 already matches the enum encoding
	assign op_dec = riscv_m_pkg::m_op_e'(i_funct3);

	// valid is the only control bit in this stage
	always_ff @(posedge i_riscv_clk)
	begin
		if (i_reset)
		begin
			req.valid <= 1'b0;
		end
		else
		begin
			req.valid <= i_valid;	// one request per clock, no stall
		end
	end

	// payload is taken on every edge
	// a bubble just carries junk with valid low
	always_ff @(posedge i_riscv_clk)
	begin
		req.op      <= op_dec;
		req.rs1data <= i_rs1data;
		req.rs2data <= i_rs2data;
		req.rd      <= i_rd;	// tag follows the operands
	end

endmodule

// ==== hw/riscv_m_pkg.sv ====
package riscv_m_pkg;

	// datapath width, one RV64 word
	localparam int XLEN = 64;

	// full product width of a 64x64 multiply
	localparam int DXLEN = 2 * XLEN;

	// destination register tag, x0..x31
	localparam int REG_W = 5;

	// funct3 width of the opcode field
	localparam int OP_W = 3;

	// funct3 bit that steers the result to the divider
	localparam int DIV_SEL_BIT = 2;

	// funct3 bit that marks divu and remu as unsigned
	localparam int UNSIGNED_BIT = 0;

	// M extension ops, encoded exactly as funct3
	typedef enum logic [OP_W-1:0] {
		MUL    = 3'b000,	// low half, sign does not matter
		MULH   = 3'b001,	// high half, signed x signed
		MULHSU = 3'b010,	// high half, signed x unsigned
		MULHU  = 3'b011,	// high half, unsigned x unsigned
		DIV    = 3'b100,	// signed quotient
		DIVU   = 3'b101,	// unsigned quotient
		REM    = 3'b110,	// signed remainder
		REMU   = 3'b111	// unsigned remainder
	} m_op_e;

	// bit 2 set means a divider op
	// bit 0 set in a divider op means unsigned
	// mul ops never look at bit 0 as a sign flag

endpackage

// ==== hw/riscv_m_req_if.sv ====
`timescale 1ns/1ps

interface riscv_m_req_if;

	logic                                valid;	// request held in the issue stage
	riscv_m_pkg::m_op_e                  op;	// decoded funct3
	logic [riscv_m_pkg::XLEN-1:0]        rs1data;	// first operand
	logic [riscv_m_pkg::XLEN-1:0]        rs2data;	// second operand
	logic [riscv_m_pkg::REG_W-1:0]       rd;	// tag that rides along to writeback

	// issue stage owns every signal
	modport issue (output valid, output op, output rs1data, output rs2data, output rd);

	// execute units only see the operands and the op
	modport exec (input op, input rs1data, input rs2data);

	// writeback needs op for the result mux
	modport wb (input valid, input op, input rd);

endinterface

// ==== hw/riscv_m_unit.sv ====
`timescale 1ns/1ps

module riscv_m_unit (
	input  logic                                i_riscv_clk,
	input  logic                                i_reset,
	input  logic                                i_valid,
	input  logic [riscv_m_pkg::OP_W-1:0]        i_funct3,
	input  logic [riscv_m_pkg::XLEN-1:0]        i_rs1data,
	input  logic [riscv_m_pkg::XLEN-1:0]        i_rs2data,
	input  logic [riscv_m_pkg::REG_W-1:0]       i_rd,
	output logic                                o_valid,
	output logic [riscv_m_pkg::XLEN-1:0]        o_result,
	output logic [riscv_m_pkg::REG_W-1:0]       o_rd
);

	logic [riscv_m_pkg::XLEN-1:0] mul_result;	// combinational, same cycle as issue
	logic [riscv_m_pkg::XLEN-1:0] div_result;

	// registered request between issue and writeback
	riscv_m_req_if req_if ();

	// stage 1, capture and decode
	riscv_m_issue u_issue (
		.i_riscv_clk (i_riscv_clk),
		.i_reset     (i_reset),
		.i_valid     (i_valid),
		.i_funct3    (i_funct3),
		.i_rs1data   (i_rs1data),
		.i_rs2data   (i_rs2data),
		.i_rd        (i_rd),
		.req         (req_if.issue)
	);

	// both units always evaluate, writeback chooses
	riscv_multiplier u_mul (
		.req                (req_if.exec),
		.o_riscv_mul_result (mul_result)
	);

	riscv_divider u_div (
		.req                (req_if.exec),
		.o_riscv_div_result (div_result)
	);

	// stage 2, select and register the result
	riscv_m_writeback u_wb (
		.i_riscv_clk  (i_riscv_clk),
		.i_reset      (i_reset),
		.req          (req_if.wb),
		.i_mul_result (mul_result),
		.i_div_result (div_result),
		.o_valid      (o_valid),
		.o_result     (o_result),
		.o_rd         (o_rd)
	);

endmodule

// ==== hw/riscv_m_writeback.sv ====
`timescale 1ns/1ps

module riscv_m_writeback (
	input  logic                                i_riscv_clk,
	input  logic                                i_reset,
	riscv_m_req_if.wb                           req,
	input  logic [riscv_m_pkg::XLEN-1:0]        i_mul_result,
	input  logic [riscv_m_pkg::XLEN-1:0]        i_div_result,
	output logic                                o_valid,
	output logic [riscv_m_pkg::XLEN-1:0]        o_result,
	output logic [riscv_m_pkg::REG_W-1:0]       o_rd
);

	logic [riscv_m_pkg::XLEN-1:0] sel_result;	// unit result picked by the op

	// funct3 bit 2 picks the divider
	assign sel_result = req.op[riscv_m_pkg::DIV_SEL_BIT] ? i_div_result : i_mul_result;

	always_ff @(posedge i_riscv_clk)
	begin
		if (i_reset)
		begin
			o_valid <= 1'b0;	// nothing in flight after reset
		end
		else
		begin
			o_valid <= req.valid;
		end
	end

	// result and tag only move on a real request
	always_ff @(posedge i_riscv_clk)
	begin
		if (req.valid)
		begin
			o_result <= sel_result;
			o_rd     <= req.rd;	// same tag that went in
		end
	end

endmodule

// ==== hw/riscv_multiplier.sv ====
`timescale 1ns/1ps

module riscv_multiplier (
	riscv_m_req_if.exec                        req,
	output logic [riscv_m_pkg::XLEN-1:0]       o_riscv_mul_result
);

	logic                                   rs1_signed;	// treat rs1 as two's complement
	logic                                   rs2_signed;	// treat rs2 as two's complement
	logic signed [riscv_m_pkg::XLEN:0]      rs1_ext;	// 65 bits, sign or zero extended
	logic signed [riscv_m_pkg::XLEN:0]      rs2_ext;
	logic signed [riscv_m_pkg::DXLEN-1:0]   product;	// low 128 bits of the exact product

	// mulh and mulhsu take rs1 as signed
	assign rs1_signed = (req.op == riscv_m_pkg::MULH) ||
	                    (req.op == riscv_m_pkg::MULHSU);

	// only mulh takes rs2 as signed
	assign rs2_signed = (req.op == riscv_m_pkg::MULH);

	// extra top bit is the sign for signed ops, zero otherwise
	assign rs1_ext = {rs1_signed & req.rs1data[riscv_m_pkg::XLEN-1], req.rs1data};
	assign rs2_ext = {rs2_signed & req.rs2data[riscv_m_pkg::XLEN-1], req.rs2data};

	// 65x65 signed covers all three sign mixes
	// the true product fits in 128 bits for every mix
	assign product = rs1_ext * rs2_ext;

	always_comb
	begin
		case (req.op)
			riscv_m_pkg::MUL:
			begin
				o_riscv_mul_result = product[riscv_m_pkg::XLEN-1:0];	// low word
			end
			riscv_m_pkg::MULH,
			riscv_m_pkg::MULHSU,
			riscv_m_pkg::MULHU:
			begin
				// high word, sign handled by the extension above
				o_riscv_mul_result = product[riscv_m_pkg::DXLEN-1:riscv_m_pkg::XLEN];
			end
			default:
			begin
				o_riscv_mul_result = '0;	// divider op, writeback ignores this
			end
		endcase
	end

endmodule

// ==== list.f ====
hw/riscv_m_pkg.sv
hw/riscv_m_req_if.sv
hw/riscv_m_issue.sv
hw/riscv_multiplier.sv
hw/riscv_divider.sv
hw/riscv_m_writeback.sv
hw/riscv_m_unit.sv
bench/riscv_m_checker.sv
bench/tb_riscv_m_unit.sv
